// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = exec_unit_tb
FLIST = all.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
common/exec_pkg.sv
alu/seq_multiplier.sv
alu/alu.sv
rtl/operand_dispatch.sv
rtl/op_fifo.sv
rtl/exec_unit_top.sv
verification/exec_unit_tb.sv

// ==== alu/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                flush,
    input  wire exec_pkg::prep_op_t  head,
    input  wire logic                empty,
    output logic                     pop,
    output logic [63:0]              res,
    output logic                     res_valid,
    output logic                     busy
);
    import exec_pkg::*;

    typedef enum logic {
        alu_idle,
        alu_mul_wait
    } alu_state_e;

    alu_state_e            state;
    logic [xlen-1:0]       a;
    logic [xlen-1:0]       b;
    logic [shamt_w-1:0]    sh;
    logic [xlen-1:0]       result;
    logic                  div_zero;
    logic                  div_ovf;
    logic                  start;
    logic                  single_done;
    logic                  done;
    logic [xlen-1:0]       product;

    assign a  = head.a;
    assign b  = head.b;
    assign sh = b[shamt_w-1:0];

    assign div_zero = (b == '0);
    // most negative value over minus one
    assign div_ovf  = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);

    always_comb begin
        case (head.op)
            op_add:   result = a + b;
            op_sub:   result = a - b;
            op_ret_a: result = a;
            op_ret_b: result = b;
            op_xor:   result = a ^ b;
            op_or:    result = a | b;
            op_and:   result = a & b;
            op_sll:   result = a << sh;
            op_srl:   result = a >> sh;
            op_sra: begin
                if (head.word) begin
                    result = {{(xlen-32){1'b0}}, $signed(a[31:0]) >>> sh};
                end else begin
                    result = $signed(a) >>> sh;
                end
            end
            op_slt:   result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu:  result = {{(xlen-1){1'b0}}, a < b};
            op_eq:    result = {{(xlen-1){1'b0}}, a == b};
            op_ge:    result = {{(xlen-1){1'b0}}, $signed(a) >= $signed(b)};
            op_geu:   result = {{(xlen-1){1'b0}}, a >= b};
            op_div: begin
                if (div_zero) begin
                    result = '1;
                end else if (div_ovf) begin
                    result = a;
                end else begin
                    result = $signed(a) / $signed(b);
                end
            end
            op_divu:  result = div_zero ? '1 : a / b;
            op_rem: begin
                if (div_zero) begin
                    result = a;
                end else if (div_ovf) begin
                    result = '0;
                end else begin
                    result = $signed(a) % $signed(b);
                end
            end
            op_remu:  result = div_zero ? a : a % b;
            // multiply result comes from the sequencer
            default:  result = '0;
        endcase
    end

    assign busy        = (state == alu_mul_wait);
    assign pop         = (state == alu_idle) && !empty && !flush;
    assign start       = pop && (head.op == op_mul);
    assign single_done = pop && (head.op != op_mul);

    seq_multiplier u_mul (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .start   (start),
        .a       (a),
        .b       (b),
        .product (product),
        .done    (done)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= alu_idle;
            res_valid <= 1'b0;
        end else if (flush) begin
            state     <= alu_idle;
            res_valid <= 1'b0;
        end else begin
            case (state)
                alu_idle: begin
                    res_valid <= single_done;
                    if (start) begin
                        state <= alu_mul_wait;
                    end
                end
                alu_mul_wait: begin
                    res_valid <= done;
                    if (done) begin
                        state <= alu_idle;
                    end
                end
                default: begin
                    state     <= alu_idle;
                    res_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (single_done) begin
            res <= result;
        end else if (busy && done) begin
            res <= product;
        end
    end

    // a result never shows while a multiply holds the unit
    a_no_res_mid_mul: assert property (
        @(posedge clk) disable iff (!arst_n || flush)
        busy |-> !res_valid
    ) else $error("res_valid while multiply busy");

    // queue is held for the whole multiply
    a_no_pop_in_mul: assert property (
        @(posedge clk) disable iff (!arst_n || flush)
        start |=> (!pop) [*mul_cycles]
    ) else $error("pop while multiply busy");

endmodule

`default_nettype wire

// ==== alu/seq_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire logic         flush,
    input  wire logic         start,
    input  wire logic [63:0]  a,
    input  wire logic [63:0]  b,
    output logic [63:0]       product,
    output logic              done
);
    import exec_pkg::*;

    logic                   running;
    logic [mul_cnt_w-1:0]   cnt;
    logic [xlen-1:0]        acc;
    logic [xlen-1:0]        mcand;
    logic [xlen-1:0]        mplier;

    // partial sum including the current multiplier bit
    assign product = acc + (mplier[0] ? mcand : '0);

    // last iteration is folded into product, so done lands on the final cycle
    assign done = running && (cnt == mul_cnt_w'(mul_cycles - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (flush) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (start) begin
            running <= 1'b1;
            cnt     <= '0;
        end else if (done) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (running) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= a;
            mplier <= b;
        end else if (running) begin
            acc    <= product;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== common/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // datapath and buffer sizes
    localparam int xlen       = 64;
    localparam int shamt_w    = 6;
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;
    localparam int mul_cycles = 64;
    localparam int mul_cnt_w  = 6;

    // alu operation codes, codes above op_remu are unused
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_ret_a,
        op_ret_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_e;

    // first operand source
    typedef enum logic {
        sel_a_pc,
        sel_a_rs1
    } sel_a_e;

    // second operand source
    typedef enum logic [1:0] {
        sel_b_imm,
        sel_b_rs2,
        sel_b_csr
    } sel_b_e;

    // one operation as it leaves issue
    typedef struct packed {
        alu_op_e           op;
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   rs1;
        logic [xlen-1:0]   rs2;
        logic [xlen-1:0]   csr;
        logic [xlen-1:0]   imm;
        sel_a_e            sel_a;
        sel_b_e            sel_b;
        // use only the low 32 bits of rs1
        logic              word;
    } issue_t;

    // operation with both operands resolved
    typedef struct packed {
        alu_op_e           op;
        logic [xlen-1:0]   a;
        logic [xlen-1:0]   b;
        logic              word;
    } prep_op_t;

endpackage

`default_nettype wire

// ==== rtl/exec_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_top (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              flush,
    input  wire logic              issue_valid,
    input  wire exec_pkg::issue_t  issue,
    output logic                   issue_ready,
    output logic [63:0]            res,
    output logic                   res_valid,
    output logic                   busy
);
    import exec_pkg::*;

    logic       push;
    prep_op_t   push_op;
    logic       full;
    prep_op_t   head;
    logic       empty;
    logic       pop;

    operand_dispatch u_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .full        (full),
        .issue_ready (issue_ready),
        .push        (push),
        .push_op     (push_op)
    );

    op_fifo u_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .push    (push),
        .push_op (push_op),
        .pop     (pop),
        .head    (head),
        .empty   (empty),
        .full    (full)
    );

    alu u_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .res       (res),
        .res_valid (res_valid),
        .busy      (busy)
    );

endmodule

`default_nettype wire

// ==== rtl/op_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_fifo (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                flush,
    input  wire logic                push,
    input  wire exec_pkg::prep_op_t  push_op,
    input  wire logic                pop,
    output exec_pkg::prep_op_t       head,
    output logic                     empty,
    output logic                     full
);
    import exec_pkg::*;

    prep_op_t                mem [fifo_depth];
    logic [fifo_ptr_w-1:0]   wr_ptr;
    logic [fifo_ptr_w-1:0]   rd_ptr;
    logic [fifo_ptr_w:0]     count;
    logic                    wr_en;
    logic                    rd_en;

    assign empty = (count == '0);
    assign full  = (count == (fifo_ptr_w+1)'(fifo_depth));
    assign wr_en = push && !full && !flush;
    assign rd_en = pop && !empty && !flush;

    // show-ahead head entry
    assign head = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_op;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !full
    ) else $error("push into full queue");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("pop from empty queue");

endmodule

`default_nettype wire

// ==== rtl/operand_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_dispatch (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              flush,
    input  wire logic              issue_valid,
    input  wire exec_pkg::issue_t  issue,
    input  wire logic              full,
    output logic                   issue_ready,
    output logic                   push,
    output exec_pkg::prep_op_t     push_op
);
    import exec_pkg::*;

    prep_op_t          prep;
    prep_op_t          op_q;
    logic              push_q;
    logic              accept;
    logic [xlen-1:0]   rs1_view;

    // word operations see rs1 zero-extended from bit 31
    assign rs1_view = issue.word ? {{(xlen-32){1'b0}}, issue.rs1[31:0]} : issue.rs1;

    always_comb begin
        prep.op   = issue.op;
        prep.word = issue.word;
        prep.a    = (issue.sel_a == sel_a_rs1) ? rs1_view : issue.pc;
        case (issue.sel_b)
            sel_b_rs2: prep.b = issue.rs2;
            sel_b_csr: prep.b = issue.csr;
            default:   prep.b = issue.imm;
        endcase
    end

    // the staging register counts as a queue slot while its push is pending
    assign issue_ready = !full && !push_q;

    // an issue in a flush cycle is dropped
    assign accept = issue_valid && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push_q <= 1'b0;
        end else if (flush) begin
            push_q <= 1'b0;
        end else begin
            push_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= prep;
        end
    end

    assign push    = push_q;
    assign push_op = op_q;

    // source must respect ready, which depends on the queue state
    a_issue_when_ready: assert property (
        @(posedge clk) disable iff (!arst_n)
        issue_valid |-> issue_ready
    ) else $error("issue_valid while issue_ready low");

endmodule

`default_nettype wire

// ==== verification/exec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;
    import exec_pkg::*;

    // rough cycle budget per test, the run limit is twice their sum
    localparam int reset_cycles = 12;
    localparam int len_basic    = 150;
    localparam int len_compare  = 150;
    localparam int len_mul      = 4 * (mul_cycles + 16);
    localparam int len_div      = 150;
    localparam int len_backpr   = 8 * (mul_cycles + 8);
    localparam int len_flush    = mul_cycles + 100;
    localparam int run_limit    = 2 * (reset_cycles + len_basic + len_compare + len_mul
                                       + len_div + len_backpr + len_flush);

    logic          clk;
    logic          arst_n;
    logic          flush;
    logic          issue_valid;
    issue_t        issue;
    logic          issue_ready;
    logic [63:0]   res;
    logic          res_valid;
    logic          busy;

    logic [63:0]   exp_q [$];
    logic [63:0]   exp_front;
    int            exp_count;
    int            err_count;
    int            tests_run;
    int            tests_bad;
    int            cycle_count;
    int            busy_len;
    int            not_ready_len;
    logic          flush_seen;

    exec_unit_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .res         (res),
        .res_valid   (res_valid),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // result expected by the operation rules
    function automatic logic [63:0] expected_result(issue_t it);
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        logic [63:0] ext;
        logic [63:0] mag_a;
        logic [63:0] mag_b;
        logic [63:0] q;
        logic        lt_s;
        logic        lt_u;
        logic [63:0] val;
        if (it.sel_a == sel_a_pc) begin
            a = it.pc;
        end else if (it.word) begin
            a = {32'h0, it.rs1[31:0]};
        end else begin
            a = it.rs1;
        end
        case (it.sel_b)
            sel_b_rs2: b = it.rs2;
            sel_b_csr: b = it.csr;
            default:   b = it.imm;
        endcase
        sh = b[5:0];
        lt_u = (a < b);
        // differing signs decide a signed compare by the sign of a
        lt_s = (a[63] != b[63]) ? a[63] : lt_u;
        mag_a = a[63] ? -a : a;
        mag_b = b[63] ? -b : b;
        case (it.op)
            op_add:   val = a + b;
            op_sub:   val = a - b;
            op_ret_a: val = a;
            op_ret_b: val = b;
            op_xor:   val = a ^ b;
            op_or:    val = a | b;
            op_and:   val = a & b;
            op_sll:   val = a << sh;
            op_srl:   val = a >> sh;
            op_sra: begin
                if (it.word) begin
                    ext = {{32{a[31]}}, a[31:0]};
                    ext = $signed(ext) >>> sh;
                    val = {32'h0, ext[31:0]};
                end else begin
                    val = $signed(a) >>> sh;
                end
            end
            op_slt:   val = {63'h0, lt_s};
            op_sltu:  val = {63'h0, lt_u};
            op_eq:    val = {63'h0, a == b};
            op_ge:    val = {63'h0, !lt_s};
            op_geu:   val = {63'h0, !lt_u};
            op_mul:   val = a * b;
            // min over minus one falls out of the magnitude form as a, remainder 0
            op_div: begin
                if (b == '0) begin
                    val = '1;
                end else begin
                    q = mag_a / mag_b;
                    val = (a[63] ^ b[63]) ? -q : q;
                end
            end
            op_rem: begin
                if (b == '0) begin
                    val = a;
                end else begin
                    q = mag_a % mag_b;
                    val = a[63] ? -q : q;
                end
            end
            op_divu:  val = (b == '0) ? '1 : a / b;
            op_remu:  val = (b == '0) ? a : a % b;
            default:  val = '0;
        endcase
        return val;
    endfunction

    function automatic issue_t make_issue(alu_op_e op, logic word);
        issue_t      it;
        int unsigned pick;
        it.op   = op;
        it.pc   = {$urandom, $urandom};
        it.rs1  = {$urandom, $urandom};
        it.rs2  = {$urandom, $urandom};
        it.csr  = {$urandom, $urandom};
        it.imm  = {$urandom, $urandom};
        it.word = word;
        it.sel_a = ($urandom_range(0, 1) == 0) ? sel_a_pc : sel_a_rs1;
        pick = $urandom_range(0, 2);
        it.sel_b = (pick == 0) ? sel_b_imm : (pick == 1) ? sel_b_rs2 : sel_b_csr;
        return it;
    endfunction

    task automatic sync_front();
        exp_count = exp_q.size();
        if (exp_q.size() > 0) begin
            exp_front = exp_q[0];
        end else begin
            exp_front = '0;
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic send(issue_t it);
        while (!issue_ready) begin
            @(negedge clk);
        end
        issue_valid = 1'b1;
        issue       = it;
        exp_q.push_back(expected_result(it));
        sync_front();
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic finish_test(string name, int errs_at_start);
        tests_run = tests_run + 1;
        if (err_count == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad = tests_bad + 1;
            $display("test %s: %0d errors", name, err_count - errs_at_start);
        end
    endtask

    // retire the front expectation one edge after each result pulse
    always @(posedge clk) begin
        if (arst_n && res_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            sync_front();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        busy_len    <= busy ? busy_len + 1 : 0;
        flush_seen  <= flush;
        if (!arst_n || issue_ready) begin
            not_ready_len <= 0;
        end else begin
            not_ready_len <= not_ready_len + 1;
        end
        if (cycle_count >= run_limit) begin
            $display("timeout: run still going after %0d cycles", run_limit);
            $display("tests failed");
            $finish;
        end
    end

    chk_res_value: assert property (
        @(negedge clk) disable iff (!arst_n)
        (res_valid && exp_count > 0) |-> (res == exp_front)
    ) else begin
        $display("FAILED at %0t: res expected %h actual %h", $time, exp_front, res);
        err_count = err_count + 1;
    end

    chk_res_expected: assert property (
        @(negedge clk) disable iff (!arst_n)
        res_valid |-> (exp_count > 0)
    ) else begin
        $display("error at %0t: a result arrived with no operation outstanding", $time);
        err_count = err_count + 1;
    end

    chk_busy_reset: assert property (
        @(posedge clk)
        $rose(arst_n) |-> !busy
    ) else begin
        $display("error at %0t: busy is high right after reset", $time);
        err_count = err_count + 1;
    end

    chk_busy_len: assert property (
        @(negedge clk) disable iff (!arst_n)
        ($fell(busy) && res_valid) |-> (busy_len == mul_cycles)
    ) else begin
        $display("FAILED at %0t: busy cycles expected %0d actual %0d",
                 $time, mul_cycles, busy_len);
        err_count = err_count + 1;
    end

    chk_ready_back: assert property (
        @(negedge clk) disable iff (!arst_n)
        not_ready_len <= mul_cycles + 8
    ) else begin
        $display("error at %0t: issue_ready stayed low too long", $time);
        err_count = err_count + 1;
    end

    chk_flush_clear: assert property (
        @(negedge clk) disable iff (!arst_n)
        flush_seen |-> (!busy && !res_valid)
    ) else begin
        $display("error at %0t: busy or a result still present after flush", $time);
        err_count = err_count + 1;
    end

    initial begin
        alu_op_e basic_ops [7];
        alu_op_e cmp_ops [8];
        alu_op_e div_ops [4];
        issue_t  it;
        int      errs;
        basic_ops = '{op_add, op_sub, op_ret_a, op_ret_b, op_xor, op_or, op_and};
        cmp_ops   = '{op_sll, op_srl, op_sra, op_slt, op_sltu, op_eq, op_ge, op_geu};
        div_ops   = '{op_div, op_divu, op_rem, op_remu};
        void'($urandom(88));
        arst_n      = 1'b0;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        err_count   = 0;
        tests_run   = 0;
        tests_bad   = 0;
        cycle_count   = 0;
        busy_len      = 0;
        not_ready_len = 0;
        flush_seen    = 1'b0;
        sync_front();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        errs = err_count;
        for (int i = 0; i < 40; i++) begin
            send(make_issue(basic_ops[$urandom_range(0, 6)], 1'b0));
        end
        wait_results();
        finish_test("arith and logic", errs);

        errs = err_count;
        for (int i = 0; i < 40; i++) begin
            send(make_issue(cmp_ops[$urandom_range(0, 7)], 1'($urandom_range(0, 1))));
        end
        // equal operands for eq, ge and geu
        for (int i = 0; i < 3; i++) begin
            it = make_issue(cmp_ops[5 + i], 1'b0);
            it.sel_a = sel_a_rs1;
            it.sel_b = sel_b_rs2;
            it.rs2   = it.rs1;
            send(it);
        end
        // word shift with upper rs1 bits set and a negative low word
        it = make_issue(op_sra, 1'b1);
        it.sel_a = sel_a_rs1;
        it.rs1   = 64'hdead_beef_8000_1234;
        it.sel_b = sel_b_imm;
        it.imm   = 64'd7;
        send(it);
        wait_results();
        finish_test("shifts and compares", errs);

        errs = err_count;
        for (int i = 0; i < 3; i++) begin
            send(make_issue(op_mul, 1'b0));
            for (int j = 0; j < 3; j++) begin
                send(make_issue(basic_ops[$urandom_range(0, 6)], 1'b0));
            end
        end
        wait_results();
        finish_test("multiply", errs);

        errs = err_count;
        for (int i = 0; i < 24; i++) begin
            it = make_issue(div_ops[$urandom_range(0, 3)], 1'b0);
            if (i % 2 == 0) begin
                it.sel_b = sel_b_rs2;
                it.rs2   = 64'($urandom_range(1, 1000));
                if (i % 4 == 0) begin
                    it.rs2 = -it.rs2;
                end
            end
            send(it);
        end
        for (int i = 0; i < 4; i++) begin
            it = make_issue(div_ops[i], 1'b0);
            it.sel_b = sel_b_rs2;
            it.rs2   = '0;
            send(it);
        end
        for (int i = 0; i < 4; i++) begin
            it = make_issue(div_ops[i], 1'b0);
            it.sel_a = sel_a_rs1;
            it.rs1   = 64'h8000_0000_0000_0000;
            it.sel_b = sel_b_rs2;
            it.rs2   = '1;
            send(it);
        end
        wait_results();
        finish_test("divide and remainder", errs);

        errs = err_count;
        // more multiplies than the queue holds
        for (int i = 0; i < 7; i++) begin
            send(make_issue(op_mul, 1'b0));
        end
        wait_results();
        finish_test("back-pressure", errs);

        errs = err_count;
        send(make_issue(op_mul, 1'b0));
        send(make_issue(op_add, 1'b0));
        send(make_issue(op_xor, 1'b0));
        while (!busy) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        while (!issue_ready) begin
            @(negedge clk);
        end
        // issue in the flush cycle is dropped, so no expectation for it
        flush       = 1'b1;
        issue_valid = 1'b1;
        issue       = make_issue(op_add, 1'b0);
        exp_q.delete();
        sync_front();
        @(negedge clk);
        flush       = 1'b0;
        issue_valid = 1'b0;
        repeat (3) @(negedge clk);
        send(make_issue(op_sub, 1'b0));
        send(make_issue(op_mul, 1'b0));
        wait_results();
        finish_test("flush", errs);

        $display("tests run %0d, with errors %0d, check failures %0d",
                 tests_run, tests_bad, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
